/* Bender.yml */
package:
  name: rv32i_pipe

export_include_dirs:
  - .

sources:
  - rv_pkg.sv
  - hazardIf.sv
  - controlUnit.sv
  - alu.sv
  - regFile.sv
  - dataMem.sv
  - hazardUnit.sv
  - cpu.sv
  - target: test
    files:
      - cpu_chk.sv
      - cpu_tb.sv

/* alu.sv */
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t  srcA,
    input  rv_pkg::word_t  srcB,
    input  rv_pkg::aluOp_t op,
    output rv_pkg::word_t  result,
    output logic           zero,
    output logic           lessS,
    output logic           lessU
);
    import rv_pkg::*;

    // Flags come straight from the operands
    assign lessS = $signed(srcA) < $signed(srcB);
    assign lessU = srcA < srcB;
    assign zero = result == '0;

    always_comb
    begin
        case (op)
            aluAdd:   result = srcA + srcB;
            aluSub:   result = srcA - srcB;
            aluAnd:   result = srcA & srcB;
            aluOr:    result = srcA | srcB;
            aluXor:   result = srcA ^ srcB;
            aluSlt:   result = word_t'(lessS);
            aluSltu:  result = word_t'(lessU);
            aluSll:   result = srcA << srcB[4:0];
            aluSrl:   result = srcA >> srcB[4:0];
            aluSra:   result = $signed(srcA) >>> srcB[4:0];
            aluPassB: result = srcB;   // lui
            default:  result = '0;
        endcase
    end
endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit (
    input  rv_pkg::word_t      instr,
    output logic               regWrite,
    output logic               memWrite,
    output logic               memRead,
    output logic               branch,
    output logic               jump,
    output logic               jumpReg,
    output logic               aluSrcImm,
    output rv_pkg::aluOp_t     aluOp,
    output rv_pkg::resultSel_t resultSel,
    output rv_pkg::memWidth_t  memWidth,
    output rv_pkg::word_t      imm
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    immSel_t    immSel;
    aluOp_t     arithOp;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign memWidth = funct3;   // Also the branch condition

    // opcode[5] separates register ops from immediate ops
    always_comb
    begin
        case (funct3)
            3'b000: arithOp = (instr[30] && opcode[5]) ? aluSub : aluAdd;
            3'b001: arithOp = aluSll;
            3'b010: arithOp = aluSlt;
            3'b011: arithOp = aluSltu;
            3'b100: arithOp = aluXor;
            3'b101: arithOp = instr[30] ? aluSra : aluSrl;
            3'b110: arithOp = aluOr;
            default: arithOp = aluAnd;
        endcase
    end

    always_comb
    begin
        regWrite = 1'b0;
        memWrite = 1'b0;
        memRead = 1'b0;
        branch = 1'b0;
        jump = 1'b0;
        jumpReg = 1'b0;
        aluSrcImm = 1'b0;
        aluOp = aluAdd;
        resultSel = resAlu;
        immSel = immI;
        case (opcode)
            7'b0110111:   // lui
            begin
                regWrite = 1'b1;
                aluSrcImm = 1'b1;
                aluOp = aluPassB;
                immSel = immU;
            end
            7'b0010011:
            begin
                // No shift-immediate forms
                if (funct3 != 3'b001 && funct3 != 3'b101)
                begin
                    regWrite = 1'b1;
                    aluSrcImm = 1'b1;
                    aluOp = arithOp;
                end
            end
            7'b0110011:
            begin
                regWrite = 1'b1;
                aluOp = arithOp;
            end
            7'b0000011:
            begin
                regWrite = 1'b1;
                memRead = 1'b1;
                aluSrcImm = 1'b1;
                resultSel = resMem;
            end
            7'b0100011:
            begin
                memWrite = 1'b1;
                aluSrcImm = 1'b1;
                immSel = immS;
            end
            7'b1100011:
            begin
                branch = 1'b1;
                aluOp = aluSub;   // zero flag for beq/bne
                immSel = immB;
            end
            7'b1101111:
            begin
                regWrite = 1'b1;
                jump = 1'b1;
                resultSel = resPc4;
                immSel = immJ;
            end
            7'b1100111:
            begin
                regWrite = 1'b1;
                jump = 1'b1;
                jumpReg = 1'b1;
                aluSrcImm = 1'b1;
                resultSel = resPc4;
            end
            default: ;   // Bubble
        endcase
    end

    always_comb
    begin
        case (immSel)
            immI: imm = {{20{instr[31]}}, instr[31:20]};
            immS: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            immB: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            immU: imm = {instr[31:12], 12'b0};
            immJ: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end
endmodule

/* cpu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module cpu (
    input  logic          clk,
    input  logic          rstN,
    input  rv_pkg::word_t ioin,
    output rv_pkg::word_t a0
);
    import rv_pkg::*;

    localparam int IW = $clog2(`RV_IMEM_WORDS);

    // Fetch
    word_t pcF, pcPlus4F, pcNext, instrF;
    word_t imem [`RV_IMEM_WORDS];

    // Decode
    word_t      instrD, pcD, pcPlus4D, rd1D, rd2D, immD;
    regIdx_t    rs1D, rs2D, rdD;
    logic       regWriteD, memWriteD, memReadD, branchD, jumpD, jumpRegD, aluSrcImmD;
    aluOp_t     aluOpD;
    resultSel_t resultSelD;
    memWidth_t  memWidthD;

    // Execute
    word_t      rd1E, rd2E, pcE, pcPlus4E, immE;
    word_t      srcAE, srcBE, writeDataE, aluResultE, targetE;
    regIdx_t    rs1E, rs2E, rdE;
    logic       regWriteE, memWriteE, memReadE, branchE, jumpE, jumpRegE, aluSrcImmE;
    logic       zeroE, lessSE, lessUE, takeE, pcSrcE;
    aluOp_t     aluOpE;
    resultSel_t resultSelE;
    memWidth_t  memWidthE;

    // Memory
    word_t      aluResultM, writeDataM, pcPlus4M, readDataM, fwdValM;
    regIdx_t    rdM;
    logic       regWriteM, memWriteM;
    resultSel_t resultSelM;
    memWidth_t  memWidthM;

    // Writeback
    word_t      aluResultW, readDataW, pcPlus4W, resultW;
    regIdx_t    rdW;
    logic       regWriteW;
    resultSel_t resultSelW;

    hazardIf hz ();

    initial
    begin
        $readmemh("program.hex", imem);
    end

    assign pcPlus4F = pcF + 32'd4;
    assign instrF = imem[pcF[IW+1:2]];
    assign pcNext = pcSrcE ? targetE : pcPlus4F;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            pcF <= '0;
        else if (!hz.stallF)
            pcF <= pcNext;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN || hz.flushD)
            instrD <= '0;   // Opcode 0 decodes as a bubble
        else if (!hz.stallD)
            instrD <= instrF;
        if (!hz.stallD)
        begin
            pcD <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD = instrD[11:7];

    controlUnit ctrl (
        .instr(instrD), .regWrite(regWriteD), .memWrite(memWriteD), .memRead(memReadD),
        .branch(branchD), .jump(jumpD), .jumpReg(jumpRegD), .aluSrcImm(aluSrcImmD),
        .aluOp(aluOpD), .resultSel(resultSelD), .memWidth(memWidthD), .imm(immD)
    );

    regFile rf (
        .clk(clk), .rstN(rstN), .rs1(rs1D), .rs2(rs2D), .rd(rdW), .we(regWriteW),
        .wd(resultW), .rd1(rd1D), .rd2(rd2D), .x10(a0)
    );

    always_ff @(posedge clk)
    begin
        if (!rstN || hz.flushE)
        begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memReadE <= 1'b0;
            branchE <= 1'b0;
            jumpE <= 1'b0;
        end
        else
        begin
            regWriteE <= regWriteD && (rdD != '0);   // x0 is never written
            memWriteE <= memWriteD;
            memReadE <= memReadD;
            branchE <= branchD;
            jumpE <= jumpD;
        end
        jumpRegE <= jumpRegD;
        aluSrcImmE <= aluSrcImmD;
        aluOpE <= aluOpD;
        resultSelE <= resultSelD;
        memWidthE <= memWidthD;
        rd1E <= rd1D;
        rd2E <= rd2D;
        pcE <= pcD;
        pcPlus4E <= pcPlus4D;
        immE <= immD;
        rs1E <= rs1D;
        rs2E <= rs2D;
        rdE <= rdD;
    end

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal, word_t wbVal, word_t memVal);
        case (sel)
            fwdWb:   return wbVal;
            fwdMem:  return memVal;
            default: return regVal;
        endcase
    endfunction

    // A jump in memory forwards its link address
    assign fwdValM = (resultSelM == resPc4) ? pcPlus4M : aluResultM;
    assign srcAE = fwdMux(hz.fwdA, rd1E, resultW, fwdValM);
    assign writeDataE = fwdMux(hz.fwdB, rd2E, resultW, fwdValM);
    assign srcBE = aluSrcImmE ? immE : writeDataE;

    alu aluE (
        .srcA(srcAE), .srcB(srcBE), .op(aluOpE), .result(aluResultE),
        .zero(zeroE), .lessS(lessSE), .lessU(lessUE)
    );

    always_comb
    begin
        case (memWidthE)   // funct3 of the branch
            3'b000:  takeE = zeroE;
            3'b001:  takeE = !zeroE;
            3'b100:  takeE = lessSE;
            3'b101:  takeE = !lessSE;
            3'b110:  takeE = lessUE;
            3'b111:  takeE = !lessUE;
            default: takeE = 1'b0;
        endcase
    end

    assign pcSrcE = (branchE && takeE) || jumpE;
    assign targetE = jumpRegE ? {aluResultE[31:1], 1'b0} : pcE + immE;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
        end
        else
        begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
        end
        resultSelM <= resultSelE;
        memWidthM <= memWidthE;
        aluResultM <= aluResultE;
        writeDataM <= writeDataE;
        rdM <= rdE;
        pcPlus4M <= pcPlus4E;
    end

    dataMem dmem (
        .clk(clk), .addr(aluResultM), .wdata(writeDataM), .memWrite(memWriteM),
        .width(memWidthM), .ioin(ioin), .rdata(readDataM)
    );

    always_ff @(posedge clk)
    begin
        if (!rstN)
            regWriteW <= 1'b0;
        else
            regWriteW <= regWriteM;
        resultSelW <= resultSelM;
        aluResultW <= aluResultM;
        readDataW <= readDataM;
        rdW <= rdM;
        pcPlus4W <= pcPlus4M;
    end

    always_comb
    begin
        case (resultSelW)
            resMem:  resultW = readDataW;
            resPc4:  resultW = pcPlus4W;
            default: resultW = aluResultW;
        endcase
    end

    assign hz.rs1D = rs1D;
    assign hz.rs2D = rs2D;
    assign hz.rs1E = rs1E;
    assign hz.rs2E = rs2E;
    assign hz.rdE = rdE;
    assign hz.rdM = rdM;
    assign hz.rdW = rdW;
    assign hz.memReadE = memReadE;
    assign hz.regWriteM = regWriteM;
    assign hz.regWriteW = regWriteW;
    assign hz.pcSrcE = pcSrcE;

    hazardUnit hzu (
        .hz(hz)
    );
endmodule

/* cpu_chk.sv */
`timescale 1ns/1ps

module cpu_chk (
    input logic            clk,
    input logic            rstN,
    input logic            flushD,
    input logic            stallF,
    input logic            stallD,
    input logic            regWriteD,
    input logic            regWriteW,
    input rv_pkg::regIdx_t rdW
);
    int assertFails = 0;

    // Flushed decode slot must hold a bubble
    flushBubble: assert property (@(posedge clk) disable iff (!rstN) flushD |=> !regWriteD)
    else
    begin
        $error("decode stage enabled a register write right after a flush");
        assertFails++;
    end

    // Load-use stall inserts a single bubble
    stallOnce: assert property (@(posedge clk) disable iff (!rstN)
                                stallF |=> !stallF && !stallD)
    else
    begin
        $error("load-use stall held fetch and decode for more than one cycle");
        assertFails++;
    end

    noX0Write: assert property (@(posedge clk) disable iff (!rstN) regWriteW |-> rdW != '0)
    else
    begin
        $error("writeback enabled a write to x0");
        assertFails++;
    end
endmodule

/* cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb;
    import rv_pkg::*;

    localparam int testCycles = 400;
    localparam int numTests = 16;   // reset check, 3 directed, 12 random
    localparam int timeoutCycles = numTests * testCycles + 100;

    logic  clk;
    logic  rstN;
    word_t ioin;
    word_t a0;

    int    cycleCount = 0;
    int    testCount = 0;
    int    failCount = 0;
    word_t lcgState;

    // Request from stimulus to the compare process
    logic  checkPending = 1'b0;
    string checkName;
    word_t checkExp;

    cpu i_cpu (
        .clk(clk),
        .rstN(rstN),
        .ioin(ioin),
        .a0(a0)
    );

    bind cpu cpu_chk i_chk (
        .clk(clk), .rstN(rstN), .flushD(hz.flushD), .stallF(hz.stallF),
        .stallD(hz.stallD), .regWriteD(regWriteD), .regWriteW(regWriteW), .rdW(rdW)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    function automatic word_t lcgNext(word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Sum of 1..n plus the sign-extended low byte, n being its low nibble
    function automatic word_t expectA0(word_t ioVal);
        word_t byteVal;
        word_t sum;
        int    n;
        byteVal = {{24{ioVal[7]}}, ioVal[7:0]};
        n = ioVal[3:0];
        sum = '0;
        for (int i = 1; i <= n; i++)
            sum = sum + word_t'(i);
        return sum + byteVal;
    endfunction

    task automatic checkWord(string name, word_t expected, word_t actual);
        testCount++;
        if (actual !== expected)
        begin
            failCount++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
        else
            $display("ok     %s: a0 = %h", name, actual);
    endtask

    task automatic requestCheck(string name, word_t expected);
        checkName = name;
        checkExp = expected;
        checkPending = 1'b1;
        wait (!checkPending);
    endtask

    // Hold ioin long enough for two full program loops
    task automatic runTest(string name, word_t ioVal);
        @(posedge clk);
        ioin <= ioVal;
        repeat (testCycles) @(posedge clk);
        requestCheck(name, expectA0(ioVal));
    endtask

    // Compare away from the active edge
    always @(negedge clk)
    begin
        if (checkPending)
        begin
            checkWord(checkName, checkExp, a0);
            checkPending = 1'b0;
        end
    end

    initial
    begin
        rstN = 1'b0;
        ioin = '0;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        repeat (4) @(posedge clk);   // x10 not yet written
        requestCheck("resetA0", '0);

        runTest("nibbleZero", 32'hdead_be70);
        runTest("fifteenIter", 32'h0000_003f);
        runTest("negativeByte", 32'h1234_56f7);

        lcgState = 32'h5b2f;
        for (int k = 0; k < 12; k++)
        begin
            lcgState = lcgNext(lcgState);
            runTest($sformatf("lcg%0d", k), {lcgState[15:0], lcgState[31:16]});
        end

        $display("Tests: %0d run, %0d failed, %0d assertion failures",
                 testCount, failCount, i_cpu.i_chk.assertFails);
        if (failCount == 0 && i_cpu.i_chk.assertFails == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        wait (cycleCount >= timeoutCycles);
        $display("Timeout: tests did not finish within %0d cycles", timeoutCycles);
        $display("Result: FAILED");
        $finish;
    end
endmodule

/* dataMem.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module dataMem (
    input  logic              clk,
    input  rv_pkg::word_t     addr,
    input  rv_pkg::word_t     wdata,
    input  logic              memWrite,
    input  rv_pkg::memWidth_t width,
    input  rv_pkg::word_t     ioin,
    output rv_pkg::word_t     rdata
);
    import rv_pkg::*;

    localparam int AW = $clog2(`RV_DMEM_BYTES);

    logic [7:0]    mem [`RV_DMEM_BYTES];
    logic [AW-1:0] base;
    logic          isIo;
    word_t         raw;

    assign base = addr[AW-1:0];
    assign isIo = addr == `RV_IO_ADDR;

    // Little endian, aligned accesses only
    assign raw = isIo ? ioin : {mem[base + AW'(3)], mem[base + AW'(2)],
                                mem[base + AW'(1)], mem[base]};

    always_comb
    begin
        case (width)
            widthB:  rdata = {{24{raw[7]}}, raw[7:0]};
            widthH:  rdata = {{16{raw[15]}}, raw[15:0]};
            widthW:  rdata = raw;
            widthBU: rdata = {24'b0, raw[7:0]};
            widthHU: rdata = {16'b0, raw[15:0]};
            default: rdata = raw;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (memWrite && !isIo)
        begin
            mem[base] <= wdata[7:0];
            if (width == widthH || width == widthW)
                mem[base + AW'(1)] <= wdata[15:8];
            if (width == widthW)
            begin
                mem[base + AW'(2)] <= wdata[23:16];
                mem[base + AW'(3)] <= wdata[31:24];
            end
        end
    end
endmodule

/* flist.f */
+incdir+.
rv_pkg.sv
hazardIf.sv
controlUnit.sv
alu.sv
regFile.sv
dataMem.sv
hazardUnit.sv
cpu.sv
cpu_chk.sv
cpu_tb.sv

/* hazardIf.sv */
`timescale 1ns/1ps

interface hazardIf;
    import rv_pkg::*;

    regIdx_t rs1D, rs2D;
    regIdx_t rs1E, rs2E, rdE;
    regIdx_t rdM, rdW;
    logic    memReadE, regWriteM, regWriteW;
    logic    pcSrcE;
    fwdSel_t fwdA, fwdB;
    logic    stallF, stallD, flushD, flushE;

    modport pipe (
        output rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        output memReadE, regWriteM, regWriteW, pcSrcE,
        input  fwdA, fwdB, stallF, stallD, flushD, flushE
    );

    modport unit (
        input  rs1D, rs2D, rs1E, rs2E, rdE, rdM, rdW,
        input  memReadE, regWriteM, regWriteW, pcSrcE,
        output fwdA, fwdB, stallF, stallD, flushD, flushE
    );
endinterface

/* hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit (
    hazardIf.unit hz
);
    import rv_pkg::*;

    logic lwStall;

    // Memory stage wins, it holds the younger result
    function automatic fwdSel_t pickFwd(
        regIdx_t rs,
        regIdx_t rdM,
        logic    weM,
        regIdx_t rdW,
        logic    weW
    );
        if (weM && rdM != '0 && rdM == rs)
            return fwdMem;
        if (weW && rdW != '0 && rdW == rs)
            return fwdWb;
        return fwdReg;
    endfunction

    assign hz.fwdA = pickFwd(hz.rs1E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);
    assign hz.fwdB = pickFwd(hz.rs2E, hz.rdM, hz.regWriteM, hz.rdW, hz.regWriteW);

    // Load in execute feeding the instruction in decode
    assign lwStall = hz.memReadE && hz.rdE != '0
                     && (hz.rdE == hz.rs1D || hz.rdE == hz.rs2D);

    assign hz.stallF = lwStall;
    assign hz.stallD = lwStall;
    assign hz.flushD = hz.pcSrcE;
    assign hz.flushE = lwStall || hz.pcSrcE;   // Bubble into execute
endmodule

/* program.hex */
// One 32-bit instruction word per line, starting at byte address 0x00
// Text after the word gives its byte address and assembly
10000293 // 00 addi x5, x0, 0x100
00028083 // 04 loop: lb x1, 0(x5)
00F0F113 // 08 andi x2, x1, 15
00110393 // 0C addi x7, x2, 1
00000193 // 10 addi x3, x0, 0
00100213 // 14 addi x4, x0, 1
00724463 // 18 head: blt x4, x7, body
0100006F // 1C jal x0, done
004181B3 // 20 body: add x3, x3, x4
00120213 // 24 addi x4, x4, 1
FF1FF06F // 28 jal x0, head
04301023 // 2C done: sh x3, 64(x0)
04005403 // 30 lhu x8, 64(x0)
00140533 // 34 add x10, x8, x1
FCDFF06F // 38 jal x0, loop
00000013 // 3C nop
00000013 // 40 nop
00000013 // 44 nop
00000013 // 48 nop
00000013 // 4C nop

/* regFile.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  rv_pkg::regIdx_t rs1,
    input  rv_pkg::regIdx_t rs2,
    input  rv_pkg::regIdx_t rd,
    input  logic            we,
    input  rv_pkg::word_t   wd,
    output rv_pkg::word_t   rd1,
    output rv_pkg::word_t   rd2,
    output rv_pkg::word_t   x10
);
    import rv_pkg::*;

    word_t regs [`RV_NREGS];

    // Same-cycle write is seen by the reader
    function automatic word_t readPort(regIdx_t idx);
        if (idx == '0)
            return '0;
        if (we && idx == rd)
            return wd;
        return regs[idx];
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `RV_NREGS; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
            regs[rd] <= wd;
    end

    always_comb
    begin
        rd1 = readPort(rs1);
        rd2 = readPort(rs2);
    end

    assign x10 = regs[10];
endmodule

/* rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// Datapath and register file
`define RV_XLEN 32
`define RV_NREGS 32

// Memory sizes
`define RV_IMEM_WORDS 64
`define RV_DMEM_BYTES 256

`define RV_IO_ADDR 32'h0000_0100   // Loads here return ioin

`endif

/* rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;
    typedef logic [$clog2(`RV_NREGS)-1:0] regIdx_t;

    // funct3 width codes for loads and stores
    typedef logic [2:0] memWidth_t;
    localparam memWidth_t widthB  = 3'b000;
    localparam memWidth_t widthH  = 3'b001;
    localparam memWidth_t widthW  = 3'b010;
    localparam memWidth_t widthBU = 3'b100;
    localparam memWidth_t widthHU = 3'b101;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt,
        aluSltu, aluSll, aluSrl, aluSra, aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {immI, immS, immB, immU, immJ} immSel_t;

    typedef enum logic [1:0] {resAlu, resMem, resPc4} resultSel_t;

    // Source of an execute operand
    typedef enum logic [1:0] {
        fwdReg = 2'b00,
        fwdWb  = 2'b01,
        fwdMem = 2'b10
    } fwdSel_t;

endpackage
